/* src/sha1_pkg.sv */
`default_nettype none

package sha1_pkg;

	localparam int WORD_W = 32;
	localparam int DIGEST_WORDS = 5;
	localparam int ROUNDS = 80;
	localparam int BLOCK_WORDS = 16;
	// input reg, first stage, 79 later stages, feed-forward adder
	localparam int PIPE_LATENCY = 82;
	localparam int WORD_CNT_W = $clog2(DIGEST_WORDS + 1);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [WORD_CNT_W-1:0] word_cnt_t;

	localparam word_t K_ROUND_0 = 32'h5a82_7999;
	localparam word_t K_ROUND_1 = 32'h6ed9_eba1;
	localparam word_t K_ROUND_2 = 32'h8f1b_bcdc;
	localparam word_t K_ROUND_3 = 32'hca62_c1d6;

	// padding for an 84-byte message
	localparam word_t PAD_WORD = 32'h8000_0000;
	localparam word_t MSG_LEN_BITS = 32'd672;

	// word a sits in the low 32 bits
	typedef struct packed {
		word_t e;
		word_t d;
		word_t c;
		word_t b;
		word_t a;
	} ctx_t;

	typedef word_t [BLOCK_WORDS-1:0] block_t;

	typedef struct packed {
		word_t ck;
		word_t h_term;
		word_t f_term;
		word_t e;
		word_t d;
		word_t c;
		word_t b;
		word_t a;
	} round_state_t;

	typedef enum logic [1:0] {CH, PARITY, MAJ} round_fn_e;
	typedef enum logic {PHASE_CTX, PHASE_DATA} pack_phase_e;

	function automatic word_t rotl(input word_t x, input int n);
		return (x << n) | (x >> (WORD_W - n));
	endfunction

	function automatic round_fn_e fn_of_round(input int r);
		if (r < 20)
			return CH;
		else if (r < 40)
			return PARITY;
		else if (r < 60)
			return MAJ;
		return PARITY;
	endfunction

	function automatic word_t k_of_round(input int r);
		if (r < 20)
			return K_ROUND_0;
		else if (r < 40)
			return K_ROUND_1;
		else if (r < 60)
			return K_ROUND_2;
		return K_ROUND_3;
	endfunction

	function automatic word_t f_apply(input round_fn_e fn, input word_t b, input word_t c,
		input word_t d);
		case (fn)
			CH: return d ^ (b & (c ^ d));
			MAJ: return (b & c) | (d & (b | c));
			default: return b ^ c ^ d;
		endcase
	endfunction

endpackage

`default_nettype wire

/* src/sha1_round_first.sv */
`default_nettype none
`timescale 1ns/1ps

module sha1_round_first (
	input  logic                   clk,
	input  sha1_pkg::ctx_t         prev_ctx,
	input  sha1_pkg::block_t       blk,
	input  sha1_pkg::word_t        sum_a_e,
	input  sha1_pkg::word_t        sum_w_k,
	output sha1_pkg::round_state_t state,
	output sha1_pkg::block_t       blk_out
);

	sha1_pkg::word_t a_new;
	sha1_pkg::word_t c_rot;
	sha1_pkg::word_t f_next;

	// round 0 only needs the boolean term on top of the precomputed sums
	always_comb
	begin
		a_new = sha1_pkg::f_apply(sha1_pkg::fn_of_round(0), prev_ctx.b, prev_ctx.c, prev_ctx.d)
			+ sum_a_e + sum_w_k;
		c_rot = sha1_pkg::rotl(prev_ctx.b, 30);
		f_next = sha1_pkg::f_apply(sha1_pkg::fn_of_round(1), prev_ctx.a, c_rot, prev_ctx.c);
	end

	always_ff @(posedge clk)
	begin
		state.a <= a_new;
		state.b <= prev_ctx.a;
		state.c <= c_rot;
		state.d <= prev_ctx.c;
		state.e <= prev_ctx.d;
		state.f_term <= f_next;
		// e of round 1 is the old d
		state.h_term <= prev_ctx.d + sha1_pkg::k_of_round(1) + blk[1];
		// old c turns into e two rounds on
		state.ck <= prev_ctx.c + sha1_pkg::k_of_round(2);
		blk_out <= blk;
	end

endmodule

`default_nettype wire

/* src/sha1_round.sv */
`default_nettype none
`timescale 1ns/1ps

module sha1_round #(
	parameter int ROUND = 1
) (
	input  logic                   clk,
	input  sha1_pkg::round_state_t state_in,
	input  sha1_pkg::block_t       blk,
	output sha1_pkg::round_state_t state,
	output sha1_pkg::block_t       blk_out
);

	// schedule slot of the word for round ROUND+1
	localparam int M = (ROUND + 1) % sha1_pkg::BLOCK_WORDS;
	localparam int M_2 = (M + 2) % sha1_pkg::BLOCK_WORDS;
	localparam int M_8 = (M + 8) % sha1_pkg::BLOCK_WORDS;
	localparam int M_13 = (M + 13) % sha1_pkg::BLOCK_WORDS;

	localparam sha1_pkg::round_fn_e NEXT_FN = sha1_pkg::fn_of_round(ROUND + 1);
	// ck pairs with the e of round ROUND+2
	localparam sha1_pkg::word_t CK_K = sha1_pkg::k_of_round(ROUND + 2);

	sha1_pkg::word_t a_new;
	sha1_pkg::word_t c_rot;
	sha1_pkg::word_t f_next;
	sha1_pkg::word_t w_next;
	sha1_pkg::word_t w_mix;

	always_comb
	begin
		a_new = sha1_pkg::rotl(state_in.a, 5) + state_in.f_term + state_in.h_term;
		c_rot = sha1_pkg::rotl(state_in.b, 30);
		f_next = sha1_pkg::f_apply(NEXT_FN, state_in.a, c_rot, state_in.c);
	end

	// next schedule word
	always_comb
	begin
		w_mix = blk[M] ^ blk[M_2] ^ blk[M_8] ^ blk[M_13];
		if (ROUND < 4)
			w_next = blk[M];
		else if (ROUND == 4)
			w_next = sha1_pkg::PAD_WORD;
		else if (ROUND < 14)
			w_next = '0;
		else if (ROUND == 14)
			w_next = sha1_pkg::MSG_LEN_BITS;
		else
			w_next = sha1_pkg::rotl(w_mix, 1);
	end

	always_ff @(posedge clk)
	begin
		state.a <= a_new;
		state.b <= state_in.a;
		state.c <= c_rot;
		state.d <= state_in.c;
		state.e <= state_in.d;
		state.f_term <= f_next;
		state.h_term <= state_in.ck + w_next;
		state.ck <= state_in.c + CK_K;
		blk_out <= blk;
		// expanded words replace the one sixteen rounds old
		if (ROUND >= 15)
			blk_out[M] <= w_next;
	end

endmodule

`default_nettype wire

/* src/sha1_pipeline.sv */
`default_nettype none
`timescale 1ns/1ps

module sha1_pipeline (
	input  logic             clk,
	input  logic             rst,
	input  logic             job_valid,
	input  sha1_pkg::ctx_t   job_ctx,
	input  sha1_pkg::ctx_t   job_msg,
	output logic             digest_valid,
	output sha1_pkg::ctx_t   digest
);

	localparam int LAST = sha1_pkg::ROUNDS - 1;
	// entry 0 doubles as the input register for the context
	localparam int CTX_DEPTH = sha1_pkg::PIPE_LATENCY - 1;

	logic [sha1_pkg::PIPE_LATENCY-1:0] valid_sr;
	sha1_pkg::ctx_t ctx_dly [CTX_DEPTH];
	sha1_pkg::block_t blk_pad;
	sha1_pkg::block_t blk_in;
	sha1_pkg::word_t sum_a_e;
	sha1_pkg::word_t sum_w_k;
	sha1_pkg::round_state_t stage_state [sha1_pkg::ROUNDS];
	sha1_pkg::block_t stage_blk [sha1_pkg::ROUNDS];

	// message words, marker bit, zeros, then length
	always_comb
	begin
		blk_pad = '0;
		blk_pad[0] = job_msg.a;
		blk_pad[1] = job_msg.b;
		blk_pad[2] = job_msg.c;
		blk_pad[3] = job_msg.d;
		blk_pad[4] = job_msg.e;
		blk_pad[sha1_pkg::DIGEST_WORDS] = sha1_pkg::PAD_WORD;
		blk_pad[sha1_pkg::BLOCK_WORDS-1] = sha1_pkg::MSG_LEN_BITS;
	end

	always_ff @(posedge clk)
	begin
		blk_in <= blk_pad;
		sum_a_e <= sha1_pkg::rotl(job_ctx.a, 5) + job_ctx.e;
		sum_w_k <= job_msg.a + sha1_pkg::K_ROUND_0;
		ctx_dly[0] <= job_ctx;
		for (int i = 1; i < CTX_DEPTH; i++)
			ctx_dly[i] <= ctx_dly[i-1];
	end

	sha1_round_first round_first_inst (
		.clk      (clk),
		.prev_ctx (ctx_dly[0]),
		.blk      (blk_in),
		.sum_a_e  (sum_a_e),
		.sum_w_k  (sum_w_k),
		.state    (stage_state[0]),
		.blk_out  (stage_blk[0])
	);

	for (genvar r = 1; r < sha1_pkg::ROUNDS; r++)
	begin : g_round
		sha1_round #(
			.ROUND (r)
		) round_inst (
			.clk      (clk),
			.state_in (stage_state[r-1]),
			.blk      (stage_blk[r-1]),
			.state    (stage_state[r]),
			.blk_out  (stage_blk[r])
		);
	end

	// feed-forward sum
	always_ff @(posedge clk)
	begin
		digest.a <= ctx_dly[CTX_DEPTH-1].a + stage_state[LAST].a;
		digest.b <= ctx_dly[CTX_DEPTH-1].b + stage_state[LAST].b;
		digest.c <= ctx_dly[CTX_DEPTH-1].c + stage_state[LAST].c;
		digest.d <= ctx_dly[CTX_DEPTH-1].d + stage_state[LAST].d;
		digest.e <= ctx_dly[CTX_DEPTH-1].e + stage_state[LAST].e;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[sha1_pkg::PIPE_LATENCY-2:0], job_valid};
	end

	assign digest_valid = valid_sr[sha1_pkg::PIPE_LATENCY-1];

	// a job is ten words, so none of the previous nine cycles may carry one
	a_job_spacing: assert property (@(posedge clk) disable iff (rst)
		job_valid |-> valid_sr[2*sha1_pkg::DIGEST_WORDS-2:0] == '0)
		else $error("job_valid pulses closer than ten cycles");

endmodule

`default_nettype wire

/* src/word_packer.sv */
`default_nettype none
`timescale 1ns/1ps

module word_packer (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  sha1_pkg::word_t  in_word,
	output logic             job_valid,
	output sha1_pkg::ctx_t   job_ctx,
	output sha1_pkg::ctx_t   job_msg
);

	logic word_valid_q;
	sha1_pkg::word_t word_q;
	sha1_pkg::pack_phase_e phase;
	sha1_pkg::word_cnt_t word_cnt;
	sha1_pkg::ctx_t line_q;
	sha1_pkg::ctx_t ctx_q;
	sha1_pkg::ctx_t line_next;
	logic last_word;

	// newest word enters at the top so the first one ends up in a
	assign line_next = sha1_pkg::ctx_t'({word_q,
		line_q[$bits(sha1_pkg::ctx_t)-1:sha1_pkg::WORD_W]});
	assign last_word = word_cnt == sha1_pkg::word_cnt_t'(sha1_pkg::DIGEST_WORDS - 1);

	always_ff @(posedge clk)
	begin
		word_q <= in_word;
		if (word_valid_q)
			line_q <= line_next;
		// hold the context while the message fills the line
		if (word_valid_q && last_word && phase == sha1_pkg::PHASE_CTX)
			ctx_q <= line_next;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			word_valid_q <= 1'b0;
			phase <= sha1_pkg::PHASE_CTX;
			word_cnt <= '0;
			job_valid <= 1'b0;
		end
		else
		begin
			word_valid_q <= in_valid;
			job_valid <= 1'b0;
			if (word_valid_q)
			begin
				if (last_word)
				begin
					word_cnt <= '0;
					if (phase == sha1_pkg::PHASE_CTX)
						phase <= sha1_pkg::PHASE_DATA;
					else
					begin
						phase <= sha1_pkg::PHASE_CTX;
						job_valid <= 1'b1;
					end
				end
				else
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	assign job_ctx = ctx_q;
	assign job_msg = line_q;

endmodule

`default_nettype wire

/* src/word_unpacker.sv */
`default_nettype none
`timescale 1ns/1ps

module word_unpacker (
	input  logic             clk,
	input  logic             rst,
	input  logic             digest_valid,
	input  sha1_pkg::ctx_t   digest,
	output logic             out_valid,
	output sha1_pkg::word_t  out_word
);

	sha1_pkg::ctx_t shift_q;
	sha1_pkg::word_cnt_t beats_left;

	// lowest word goes out first
	always_ff @(posedge clk)
	begin
		if (digest_valid)
			shift_q <= digest;
		else if (beats_left != '0)
			shift_q <= sha1_pkg::ctx_t'(shift_q >> sha1_pkg::WORD_W);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			beats_left <= '0;
		else if (digest_valid)
			beats_left <= sha1_pkg::word_cnt_t'(sha1_pkg::DIGEST_WORDS);
		else if (beats_left != '0)
			beats_left <= beats_left - 1'b1;
	end

	assign out_valid = beats_left != '0;
	assign out_word = shift_q.a;

	// pipeline output spacing must leave room for a whole burst
	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		digest_valid |-> beats_left == '0)
		else $error("digest arrived during an output burst");

endmodule

`default_nettype wire

/* src/sha1_stream_top.sv */
`default_nettype none
`timescale 1ns/1ps

module sha1_stream_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  sha1_pkg::word_t  in_word,
	output logic             out_valid,
	output sha1_pkg::word_t  out_word
);

	logic job_valid;
	sha1_pkg::ctx_t job_ctx;
	sha1_pkg::ctx_t job_msg;
	logic digest_valid;
	sha1_pkg::ctx_t digest;

	word_packer packer_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_word   (in_word),
		.job_valid (job_valid),
		.job_ctx   (job_ctx),
		.job_msg   (job_msg)
	);

	sha1_pipeline pipeline_inst (
		.clk          (clk),
		.rst          (rst),
		.job_valid    (job_valid),
		.job_ctx      (job_ctx),
		.job_msg      (job_msg),
		.digest_valid (digest_valid),
		.digest       (digest)
	);

	word_unpacker unpacker_inst (
		.clk          (clk),
		.rst          (rst),
		.digest_valid (digest_valid),
		.digest       (digest),
		.out_valid    (out_valid),
		.out_word     (out_word)
	);

endmodule

`default_nettype wire

/* verification/sha1_ref.svh */
`ifndef SHA1_REF_SVH
`define SHA1_REF_SVH

localparam logic [31:0] LFSR_SEED = 32'h0e7e0836;

// standard initial hash values as context, word 0 in the low bits
localparam logic [159:0] KNOWN_CTX = {32'hc3d2e1f0, 32'h10325476, 32'h98badcfe,
	32'hefcdab89, 32'h67452301};
localparam logic [159:0] KNOWN_MSG = {32'h0f1e2d3c, 32'h4b5a6978, 32'h8796a5b4,
	32'hc3d2e1f0, 32'hda39a3ee};

// taps of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] rol32(input logic [31:0] x, input int n);
	return (x << n) | (x >> (32 - n));
endfunction

// one block of an 84-byte message, then the feed-forward sum
function automatic logic [159:0] sha1_compress(input logic [159:0] ctx, input logic [159:0] msg);
	logic [31:0] w [80];
	logic [31:0] h [5];
	logic [31:0] a, b, c, d, e, f, k, t;
	for (int i = 0; i < 16; i++)
		w[i] = 32'h0;
	for (int i = 0; i < 5; i++)
	begin
		w[i] = msg[32*i +: 32];
		h[i] = ctx[32*i +: 32];
	end
	w[5] = 32'h8000_0000;
	w[15] = 32'd672;
	for (int i = 16; i < 80; i++)
		w[i] = rol32(w[i-3] ^ w[i-8] ^ w[i-14] ^ w[i-16], 1);
	a = h[0];
	b = h[1];
	c = h[2];
	d = h[3];
	e = h[4];
	for (int i = 0; i < 80; i++)
	begin
		if (i < 20)
		begin
			f = (b & c) | (~b & d);
			k = 32'h5a82_7999;
		end
		else if (i < 40)
		begin
			f = b ^ c ^ d;
			k = 32'h6ed9_eba1;
		end
		else if (i < 60)
		begin
			f = (b & c) | (b & d) | (c & d);
			k = 32'h8f1b_bcdc;
		end
		else
		begin
			f = b ^ c ^ d;
			k = 32'hca62_c1d6;
		end
		t = rol32(a, 5) + f + e + k + w[i];
		e = d;
		d = c;
		c = rol32(b, 30);
		b = a;
		a = t;
	end
	return {h[4] + e, h[3] + d, h[2] + c, h[1] + b, h[0] + a};
endfunction

`endif

/* verification/sha1_stream_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module sha1_stream_tb;

	localparam int CLK_PERIOD = 8;
	// capture edge of the tenth word to the edge that raises out_valid
	localparam int OUT_LATENCY = 84;
	localparam int N_RANDOM = 40;
	localparam int N_GAPPED = 8;
	// known, random, gapped, the discarded partial job, the job after reset
	localparam int NUM_JOBS = N_RANDOM + N_GAPPED + 3;
	localparam int DRAIN_LIMIT = 200;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	logic [31:0] in_word;
	logic out_valid;
	logic [31:0] out_word;

	logic [31:0] lfsr_q;
	logic [159:0] exp_digest_q [$];
	time exp_edge_q [$];
	logic [159:0] cur_digest;
	time cur_edge;
	logic cur_ok;
	int beat;
	int jobs_done;
	int errors;

	`include "sha1_ref.svh"

	sha1_stream_top sha1_stream_top_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_word   (in_word),
		.out_valid (out_valid),
		.out_word  (out_word)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return v;
	endfunction

	function automatic logic [159:0] rand_block();
		logic [159:0] v;
		for (int i = 0; i < 5; i++)
			v[32*i +: 32] = rand_bits(32);
		return v;
	endfunction

	task automatic put_word(input logic [31:0] w);
		@(posedge clk);
		in_valid <= 1'b1;
		in_word <= w;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic send_job(input logic [159:0] ctx, input logic [159:0] msg, input bit gapped);
		logic [319:0] words;
		words = {msg, ctx};
		for (int i = 0; i < 10; i++)
		begin
			put_word(words[32*i +: 32]);
			if (gapped && i < 9)
				idle_cycles(rand_bits(2));
		end
		exp_digest_q.push_back(sha1_compress(ctx, msg));
		exp_edge_q.push_back($time + CLK_PERIOD + OUT_LATENCY * CLK_PERIOD);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_digest_q.size() != 0 || beat != 0) && n < DRAIN_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		assert (n < DRAIN_LIMIT)
		else
		begin
			errors++;
			$display("pipeline did not drain within %0d cycles", DRAIN_LIMIT);
		end
	endtask

	task automatic pulse_reset(input int n);
		@(posedge clk);
		rst <= 1'b1;
		in_valid <= 1'b0;
		repeat (n) @(posedge clk);
		rst <= 1'b0;
	endtask

	// output side is sampled on the falling edge
	always @(negedge clk)
	begin
		if (out_valid === 1'b1)
		begin
			if (beat == 0)
			begin
				cur_ok = exp_digest_q.size() != 0;
				assert (cur_ok)
				else
				begin
					errors++;
					$display("out_valid at %0t with no job pending", $time);
				end
				if (cur_ok)
				begin
					cur_digest = exp_digest_q.pop_front();
					cur_edge = exp_edge_q.pop_front();
					assert ($time - CLK_PERIOD / 2 == cur_edge)
					else
					begin
						errors++;
						$display("mismatch at %0t: job %0d first beat at edge %0t, expected %0t",
							$time, jobs_done, $time - CLK_PERIOD / 2, cur_edge);
					end
				end
			end
			if (cur_ok)
			begin
				assert (out_word == cur_digest[32*beat +: 32])
				else
				begin
					errors++;
					$display("mismatch at %0t: job %0d word %0d got %h expected %h", $time,
						jobs_done, beat, out_word, cur_digest[32*beat +: 32]);
				end
			end
			beat++;
			if (beat == 5)
			begin
				beat = 0;
				if (cur_ok)
					jobs_done++;
			end
		end
		else
		begin
			assert (beat == 0)
			else
			begin
				errors++;
				$display("output burst of job %0d stopped after %0d beats", jobs_done, beat);
			end
			beat = 0;
		end
	end

	initial
	begin
		#((NUM_JOBS * 20 + 500) * CLK_PERIOD);
		$display("timeout: run did not finish within %0d ns", (NUM_JOBS * 20 + 500) * CLK_PERIOD);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_word = '0;
		lfsr_q = LFSR_SEED;
		beat = 0;
		cur_ok = 1'b0;
		jobs_done = 0;
		errors = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		// nothing may come out before a full job
		idle_cycles(20);
		send_job(KNOWN_CTX, KNOWN_MSG, 1'b0);
		idle_cycles(1);
		wait_drain();
		for (int j = 0; j < N_RANDOM; j++)
			send_job(rand_block(), rand_block(), 1'b0);
		idle_cycles(1);
		wait_drain();
		for (int j = 0; j < N_GAPPED; j++)
			send_job(rand_block(), rand_block(), 1'b1);
		idle_cycles(1);
		wait_drain();
		// partial job cut off by reset
		for (int i = 0; i < 4; i++)
			put_word(rand_bits(32));
		pulse_reset(2);
		idle_cycles(100);
		send_job(rand_block(), rand_block(), 1'b0);
		idle_cycles(1);
		wait_drain();
		idle_cycles(4);
		assert (jobs_done == NUM_JOBS - 1)
		else
		begin
			errors++;
			$display("only %0d of %0d jobs produced a digest", jobs_done, NUM_JOBS - 1);
		end
		$display("jobs checked: %0d, errors: %0d", jobs_done, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
src/sha1_pkg.sv
src/sha1_round_first.sv
src/sha1_round.sv
src/sha1_pipeline.sv
src/word_packer.sv
src/word_unpacker.sv
src/sha1_stream_top.sv
+incdir+verification
verification/sha1_stream_tb.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module sha1_stream_tb -Mdir obj_dir -f flist.f

run: build
	./obj_dir/Vsha1_stream_tb > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "TB FAILED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module sha1_stream_tb -f flist.f

clean:
	rm -rf obj_dir sim.log
